/* vector_unit.f */
vu_pkg.sv
vu_regfile.sv
vu_alu.sv
vu_ldst_port.sv
vu_lane.sv
vector_unit.sv
tb_vector_unit.sv

/* tb_vector_unit.sv */
// Directed testbench for the SIMT vector unit with behavioral memory responders per lane
module tb_vector_unit;

	import vu_pkg::*;

	localparam int LANES = vu_pkg::NUM_LANES;
	localparam logic [LANES-1:0] ALL_LANES = '1;

	logic					clock;
	logic					arst_n;
	logic					cmd_valid;
	op_e					cmd_op;
	reg_idx_t				cmd_rd;
	reg_idx_t				cmd_rs1;
	reg_idx_t				cmd_rs2;
	logic [LANES-1:0]		lane_en;
	tid_t					thread_id;
	data_t					scalar_in;
	data_t					scalar_out;
	logic					commit_req;
	logic [LANES-1:0]		status;
	logic [LANES-1:0]		mem_req;
	logic [LANES-1:0]		mem_we;
	addr_t [LANES-1:0]		mem_addr;
	data_t [LANES-1:0]		mem_wdata;
	logic [LANES-1:0]		mem_grant;
	data_t [LANES-1:0]		mem_rdata;
	logic [LANES-1:0]		mem_done;

	data_t	model_regs [LANES][NUM_REGS];	// Expected register contents
	logic	model_status [LANES];
	data_t	exp_mem [addr_t];				// Expected memory, stores only
	data_t	mem_words [addr_t];				// Responder memory
	int		done_count [LANES];				// mem_done pulses per lane

	vector_unit #(.NUM_LANES(LANES)) dut0 (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic data_t fill_word(addr_t a);
		return {~a, a} ^ 32'h3c5a_96e1;		// Unwritten word pattern
	endfunction

	function automatic data_t read_word(addr_t a);
		return mem_words.exists(a) ? mem_words[a] : fill_word(a);
	endfunction

	function automatic data_t mem_expect(addr_t a);
		return exp_mem.exists(a) ? exp_mem[a] : fill_word(a);
	endfunction

	////////////////////
	// Memory responders
	////////////////////
	for (genvar i = 0; i < LANES; i++) begin : g_mem
		logic	grant_r;
		logic	done_r;
		logic	we_r;
		data_t	rdata_r;
		data_t	wdata_r;
		addr_t	addr_r;

		assign mem_grant[i]	= grant_r;
		assign mem_done[i]	= done_r;
		assign mem_rdata[i]	= rdata_r;

		initial begin
			grant_r	= 1'b0;
			done_r	= 1'b0;
			rdata_r	= '0;
			forever begin
				@(negedge clock);
				if (mem_req[i]) begin
					repeat ($urandom % 4) @(negedge clock);
					addr_r	= mem_addr[i];			// Request held until grant
					wdata_r	= mem_wdata[i];
					we_r	= mem_we[i];
					grant_r	= 1'b1;
					@(negedge clock);
					grant_r	= 1'b0;
					repeat ($urandom % 4) @(negedge clock);
					if (we_r) begin
						mem_words[addr_r] = wdata_r;
					end else begin
						rdata_r = read_word(addr_r);
					end
					done_r = 1'b1;
					done_count[i]++;
					@(negedge clock);
					done_r = 1'b0;
				end
			end
		end
	end

	////////////////////
	// Checks and model
	////////////////////
	task automatic check_data(string name, data_t got, data_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
			$display("tests failed");
			$fatal(1, "data mismatch on %s", name);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
			$display("tests failed");
			$fatal(1, "flag mismatch on %s", name);
		end
	endtask

	task automatic wait_commit();
		int cycles;
		cycles = 0;
		while (commit_req !== 1'b1 && cycles < 100) begin
			@(negedge clock);
			cycles++;
		end
		if (commit_req !== 1'b1) begin
			$display("Timeout: commit_req stayed low for %0d cycles at %0t", cycles, $time);
			$display("tests failed");
			$fatal(1, "commit timeout");
		end
	endtask

	function automatic data_t alu_expect(op_e op, data_t a, data_t b, data_t s, int lane);
		case (op)
			OP_ADD:		return a + b;
			OP_SUB:		return a - b;
			OP_AND:		return a & b;
			OP_OR:		return a | b;
			OP_XOR:		return a ^ b;
			OP_SLL:		return a << b[4:0];
			OP_SRL:		return a >> b[4:0];
			OP_MOVS:	return s;
			OP_LANEID:	return data_t'(thread_id) * LANES + lane;
			default:	return '0;
		endcase
	endfunction

	function automatic void update_model(op_e op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
			logic [LANES-1:0] mask, data_t s);
		data_t a [LANES];
		data_t b [LANES];
		data_t res;
		for (int i = 0; i < LANES; i++) begin
			a[i] = model_regs[i][rs1];			// Sources before any write
			b[i] = model_regs[i][rs2];
		end
		for (int i = 0; i < LANES; i++) begin
			if (mask[i] && op != OP_RDS && op != OP_NOP) begin
				case (op)
					OP_STORE:	exp_mem[addr_t'(a[i])] = b[i];
					OP_LOAD:	model_regs[i][rd] = mem_expect(addr_t'(a[i]));
					default: begin
						if (op == OP_ROTL) begin
							res = a[(i + 1) % LANES];
						end else begin
							res = alu_expect(op, a[i], b[i], s, i);
						end
						model_regs[i][rd] = res;
						model_status[i] = (res == '0);
					end
				endcase
			end
		end
	endfunction

	task automatic run_cmd(op_e op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
			logic [LANES-1:0] mask, data_t s);
		@(negedge clock);
		cmd_op		= op;
		cmd_rd		= rd;
		cmd_rs1		= rs1;
		cmd_rs2		= rs2;
		lane_en		= mask;
		scalar_in	= s;
		cmd_valid	= 1'b1;
		@(negedge clock);
		cmd_valid	= 1'b0;						// Fields held until commit
		wait_commit();
		update_model(op, rd, rs1, rs2, mask, s);
	endtask

	task automatic read_reg(reg_idx_t r);
		for (int k = 0; k < LANES; k++) begin
			run_cmd(OP_RDS, '0, r, '0, ALL_LANES, data_t'(k));
			check_data($sformatf("scalar_out lane %0d r%0d", k, r), scalar_out,
				model_regs[k][r]);
		end
	endtask

	task automatic check_status();
		for (int i = 0; i < LANES; i++) begin
			check_bit($sformatf("status[%0d]", i), status[i], model_status[i]);
		end
	endtask

	task automatic check_done(int snap [LANES]);
		for (int i = 0; i < LANES; i++) begin
			check_bit($sformatf("mem_done seen lane %0d", i), done_count[i] == snap[i] + 1, 1'b1);
		end
	endtask

	////////////////////
	// Tests
	////////////////////
	task automatic test_reset_idle();
		check_bit("commit_req", commit_req, 1'b1);
		check_bit("mem_req", |mem_req, 1'b0);
		check_bit("mem_we", |mem_we, 1'b0);
		check_bit("status", |status, 1'b0);
		@(negedge clock);
		cmd_op		= OP_MOVS;					// Write zero, so status rises
		cmd_rd		= 3'd0;
		lane_en		= ALL_LANES;
		scalar_in	= '0;
		cmd_valid	= 1'b1;
		@(negedge clock);
		cmd_valid	= 1'b0;
		check_bit("commit_req", commit_req, 1'b0);
		@(negedge clock);
		check_bit("commit_req", commit_req, 1'b1);
		update_model(OP_MOVS, 3'd0, 3'd0, 3'd0, ALL_LANES, '0);
		check_status();
	endtask

	task automatic test_laneid_movs();
		thread_id = 8'd5;
		run_cmd(OP_LANEID, 3'd1, 3'd0, 3'd0, ALL_LANES, '0);
		run_cmd(OP_MOVS, 3'd2, 3'd0, 3'd0, ALL_LANES, 32'hc0de_1234);
		read_reg(3'd1);
		read_reg(3'd2);
	endtask

	task automatic test_random_alu();
		op_e op;
		thread_id = 8'h17;
		run_cmd(OP_LANEID, 3'd3, 3'd0, 3'd0, ALL_LANES, '0);
		run_cmd(OP_MOVS, 3'd4, 3'd0, 3'd0, ALL_LANES, $urandom);
		run_cmd(OP_XOR, 3'd5, 3'd3, 3'd4, ALL_LANES, '0);	// Distinct word per lane
		for (int n = 0; n < 24; n++) begin
			op = op_e'(($urandom % 8) + 1);					// OP_ADD to OP_MOVS
			run_cmd(op, reg_idx_t'($urandom), reg_idx_t'($urandom), reg_idx_t'($urandom),
				ALL_LANES, $urandom);
			check_status();
		end
		run_cmd(OP_SUB, 3'd6, 3'd5, 3'd5, ALL_LANES, '0);
		check_status();
		for (int r = 0; r < NUM_REGS; r++) begin
			read_reg(reg_idx_t'(r));
		end
	endtask

	task automatic test_lane_enable();
		logic [LANES-1:0] mask;
		for (int i = 0; i < LANES; i++) begin
			mask[i] = (i % 2 == 0);
		end
		run_cmd(OP_MOVS, 3'd7, 3'd0, 3'd0, mask, 32'h5555_aaaa);
		read_reg(3'd7);
		check_status();
	endtask

	task automatic test_rotate();
		thread_id = 8'h2a;
		run_cmd(OP_LANEID, 3'd1, 3'd0, 3'd0, ALL_LANES, '0);
		run_cmd(OP_MOVS, 3'd2, 3'd0, 3'd0, ALL_LANES, $urandom);
		run_cmd(OP_XOR, 3'd5, 3'd1, 3'd2, ALL_LANES, '0);
		run_cmd(OP_ROTL, 3'd6, 3'd5, 3'd0, ALL_LANES, '0);
		read_reg(3'd6);
		check_status();
	endtask

	task automatic test_store_load();
		int		snap [LANES];
		addr_t	a;
		thread_id = 8'h20;
		for (int round = 0; round < 3; round++) begin
			run_cmd(OP_LANEID, 3'd1, 3'd0, 3'd0, ALL_LANES, '0);
			run_cmd(OP_MOVS, 3'd2, 3'd0, 3'd0, ALL_LANES, 32'h4000 + ($urandom & 32'h0ff0));
			run_cmd(OP_ADD, 3'd3, 3'd1, 3'd2, ALL_LANES, '0);	// Store address per lane
			run_cmd(OP_MOVS, 3'd4, 3'd0, 3'd0, ALL_LANES, $urandom);
			run_cmd(OP_XOR, 3'd5, 3'd3, 3'd4, ALL_LANES, '0);
			snap = done_count;
			run_cmd(OP_STORE, 3'd0, 3'd3, 3'd5, ALL_LANES, '0);
			check_done(snap);
			for (int i = 0; i < LANES; i++) begin
				a = addr_t'(model_regs[i][3]);
				check_data($sformatf("mem[%h]", a), read_word(a), mem_expect(a));
			end
			run_cmd(OP_SUB, 3'd0, 3'd5, 3'd5, ALL_LANES, '0);	// Zero flag high across loads
			snap = done_count;
			run_cmd(OP_LOAD, 3'd6, 3'd3, 3'd0, ALL_LANES, '0);
			check_done(snap);
			snap = done_count;
			run_cmd(OP_LOAD, 3'd7, 3'd1, 3'd0, ALL_LANES, '0);	// Words never stored
			check_done(snap);
			read_reg(3'd6);
			read_reg(3'd7);
			check_status();
		end
	endtask

	initial begin
		void'($urandom(32'h9f30_2474));
		arst_n		= 1'b0;
		cmd_valid	= 1'b0;
		cmd_op		= OP_NOP;
		cmd_rd		= '0;
		cmd_rs1		= '0;
		cmd_rs2		= '0;
		lane_en		= '0;
		thread_id	= '0;
		scalar_in	= '0;
		for (int i = 0; i < LANES; i++) begin
			model_status[i] = 1'b0;
			for (int r = 0; r < NUM_REGS; r++) begin
				model_regs[i][r] = '0;
			end
		end
		repeat (10) @(negedge clock);
		arst_n = 1'b1;
		test_reset_idle();
		test_laneid_movs();
		test_random_alu();
		test_lane_enable();
		test_rotate();
		test_store_load();
		$display("all tests passed");
		$finish;
	end

endmodule

/* vector_unit.sv */
// SIMT vector unit top with lane array, lane bus, commit request and scalar readout
module vector_unit #(
	parameter int NUM_LANES = vu_pkg::NUM_LANES
) (
	input								clock,
	input								arst_n,
	input								cmd_valid,		// One-cycle command strobe
	input	vu_pkg::op_e				cmd_op,
	input	vu_pkg::reg_idx_t			cmd_rd,
	input	vu_pkg::reg_idx_t			cmd_rs1,
	input	vu_pkg::reg_idx_t			cmd_rs2,
	input	logic [NUM_LANES-1:0]		lane_en,		// Per-lane enable mask
	input	vu_pkg::tid_t				thread_id,
	input	vu_pkg::data_t				scalar_in,		// Also selects readout lane
	output	vu_pkg::data_t				scalar_out,
	output	logic						commit_req,		// No lane still working
	output	logic [NUM_LANES-1:0]		status,
	output	logic [NUM_LANES-1:0]		mem_req,
	output	logic [NUM_LANES-1:0]		mem_we,
	output	vu_pkg::addr_t [NUM_LANES-1:0]	mem_addr,
	output	vu_pkg::data_t [NUM_LANES-1:0]	mem_wdata,
	input	logic [NUM_LANES-1:0]		mem_grant,
	input	vu_pkg::data_t [NUM_LANES-1:0]	mem_rdata,
	input	logic [NUM_LANES-1:0]		mem_done
);

	import vu_pkg::*;

	localparam int SEL_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	data_t [NUM_LANES-1:0]	src_bus;	// Lane bus of captured first sources
	logic [NUM_LANES-1:0]	busy;

	assign commit_req	= ~|busy;
	assign scalar_out	= src_bus[scalar_in[SEL_W-1:0]];

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		vu_lane #(
			.NUM_LANES	(NUM_LANES),
			.LANE_ID	(i)
		) u_lane (
			.clock		(clock),
			.arst_n		(arst_n),
			.en			(lane_en[i]),
			.cmd_valid	(cmd_valid),
			.cmd_op		(cmd_op),
			.cmd_rd		(cmd_rd),
			.cmd_rs1	(cmd_rs1),
			.cmd_rs2	(cmd_rs2),
			.thread_id	(thread_id),
			.scalar_in	(scalar_in),
			.src_bus_in	(src_bus),
			.src_out	(src_bus[i]),
			.busy		(busy[i]),
			.status		(status[i]),
			.mem_req	(mem_req[i]),
			.mem_we		(mem_we[i]),
			.mem_addr	(mem_addr[i]),
			.mem_wdata	(mem_wdata[i]),
			.mem_grant	(mem_grant[i]),
			.mem_rdata	(mem_rdata[i]),
			.mem_done	(mem_done[i])
		);
	end

endmodule

/* vu_lane.sv */
// One SIMT lane with operand capture, lane-bus rotate, writeback and status flag
module vu_lane #(
	parameter int NUM_LANES	= vu_pkg::NUM_LANES,
	parameter int LANE_ID	= 0
) (
	input						clock,
	input						arst_n,
	input						en,				// Lane enable for this command
	input						cmd_valid,
	input	vu_pkg::op_e		cmd_op,
	input	vu_pkg::reg_idx_t	cmd_rd,
	input	vu_pkg::reg_idx_t	cmd_rs1,
	input	vu_pkg::reg_idx_t	cmd_rs2,
	input	vu_pkg::tid_t		thread_id,
	input	vu_pkg::data_t		scalar_in,
	input	vu_pkg::data_t [NUM_LANES-1:0]	src_bus_in,		// Whole lane bus
	output	vu_pkg::data_t		src_out,		// Captured first source
	output	logic				busy,
	output	logic				status,			// Last result was zero
	output	logic				mem_req,
	output	logic				mem_we,
	output	vu_pkg::addr_t		mem_addr,
	output	vu_pkg::data_t		mem_wdata,
	input						mem_grant,
	input	vu_pkg::data_t		mem_rdata,
	input						mem_done
);

	import vu_pkg::*;

	localparam int NEIGHBOUR = (LANE_ID + 1) % NUM_LANES;

	data_t		rs1_data, rs2_data;
	data_t		a_q, b_q;			// Captured operands
	op_e		op_q;
	reg_idx_t	rd_q;
	data_t		alu_result;
	data_t		ld_data;
	data_t		wb_data;
	logic		fire;
	logic		is_mem_cmd;
	logic		mem_op;
	logic		writes_rd;
	logic		alu_done;
	logic		ld_valid;
	logic		rf_we;

	assign fire			= cmd_valid && en && (cmd_op != OP_NOP);
	assign is_mem_cmd	= cmd_op inside {OP_LOAD, OP_STORE};
	assign mem_op		= op_q inside {OP_LOAD, OP_STORE};
	assign writes_rd	= !(op_q inside {OP_NOP, OP_RDS, OP_LOAD, OP_STORE});
	assign alu_done		= busy && !mem_op;	// Single-cycle ops finish here

	////////////////////
	// Operand capture
	////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			op_q	<= OP_NOP;
			busy	<= 1'b0;
		end else if (fire) begin
			op_q	<= cmd_op;
			busy	<= 1'b1;
		end else if (alu_done || ld_valid) begin
			busy	<= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (fire) begin
			rd_q	<= cmd_rd;
			a_q		<= rs1_data;
			b_q		<= rs2_data;
		end
	end

	assign src_out = a_q;

	////////////////////
	// Writeback
	////////////////////
	always_comb begin
		case (op_q)
			OP_ROTL:	wb_data = src_bus_in[NEIGHBOUR];
			OP_LOAD:	wb_data = ld_data;
			default:	wb_data = alu_result;
		endcase
	end

	assign rf_we = (alu_done && writes_rd) || (ld_valid && op_q == OP_LOAD);

	// Zero flag follows ALU and move results, loads leave it alone
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			status	<= 1'b0;
		end else if (alu_done && writes_rd) begin
			status	<= (wb_data == '0);
		end
	end

	vu_regfile u_regfile (
		.clock		(clock),
		.arst_n		(arst_n),
		.rd_addr1	(cmd_rs1),
		.rd_addr2	(cmd_rs2),
		.rd_data1	(rs1_data),
		.rd_data2	(rs2_data),
		.wr_en		(rf_we),
		.wr_addr	(rd_q),
		.wr_data	(wb_data)
	);

	vu_alu #(
		.NUM_LANES	(NUM_LANES),
		.LANE_ID	(LANE_ID)
	) u_alu (
		.op			(op_q),
		.a			(a_q),
		.b			(b_q),
		.scalar		(scalar_in),
		.thread_id	(thread_id),
		.result		(alu_result)
	);

	vu_ldst_port u_ldst (
		.clock		(clock),
		.arst_n		(arst_n),
		.start		(fire && is_mem_cmd),
		.store		(cmd_op == OP_STORE),
		.addr		(addr_t'(a_q)),			// Word address from rs1
		.wdata		(b_q),
		.mem_req	(mem_req),
		.mem_we		(mem_we),
		.mem_addr	(mem_addr),
		.mem_wdata	(mem_wdata),
		.mem_grant	(mem_grant),
		.mem_rdata	(mem_rdata),
		.mem_done	(mem_done),
		.ld_valid	(ld_valid),
		.ld_data	(ld_data)
	);

	////////////////////
	// Checks
	////////////////////
	// Scalar side must wait for commit_req, so no lane can be busy at issue
	a_issue_on_commit: assert property (@(posedge clock) disable iff (!arst_n)
		cmd_valid |-> !busy);

	a_alu_one_cycle: assert property (@(posedge clock) disable iff (!arst_n)
		(fire && !is_mem_cmd) |=> busy ##1 !busy);

endmodule

/* vu_ldst_port.sv */
// Lane load/store engine holding a memory request until grant and waiting for done
module vu_ldst_port (
	input						clock,
	input						arst_n,
	input						start,			// Memory command accepted by the lane
	input						store,			// Command is a store
	input	vu_pkg::addr_t		addr,
	input	vu_pkg::data_t		wdata,
	output	logic				mem_req,
	output	logic				mem_we,
	output	vu_pkg::addr_t		mem_addr,
	output	vu_pkg::data_t		mem_wdata,
	input						mem_grant,
	input	vu_pkg::data_t		mem_rdata,
	input						mem_done,
	output	logic				ld_valid,		// Access finished this cycle
	output	vu_pkg::data_t		ld_data
);

	import vu_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,			// Request raised, waiting for grant
		S_WAIT			// Granted, waiting for done
	} state_e;

	state_e	state;
	logic	store_q;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state	<= S_IDLE;
			store_q	<= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (start) begin
					state	<= S_REQ;
					store_q	<= store;
				end
				S_REQ: if (mem_grant) state <= S_WAIT;
				S_WAIT: if (mem_done) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	assign mem_req		= (state == S_REQ);
	assign mem_we		= (state == S_REQ) && store_q;
	assign mem_addr		= addr;				// Lane holds operands while busy
	assign mem_wdata	= wdata;

	// Stores also report completion so the lane can drop busy
	assign ld_valid		= (state == S_WAIT) && mem_done;
	assign ld_data		= mem_rdata;

	////////////////////
	// Protocol checks
	////////////////////
	a_grant_needs_req: assert property (@(posedge clock) disable iff (!arst_n)
		mem_grant |-> mem_req);

	a_done_after_grant: assert property (@(posedge clock) disable iff (!arst_n)
		mem_done |-> state == S_WAIT);

	// A new access only starts once the previous one is done
	a_start_when_idle: assert property (@(posedge clock) disable iff (!arst_n)
		start |-> state == S_IDLE);

endmodule

/* vu_alu.sv */
// Lane ALU computing arithmetic, logic, shift and move results combinationally
module vu_alu #(
	parameter int NUM_LANES	= vu_pkg::NUM_LANES,
	parameter int LANE_ID	= 0
) (
	input	vu_pkg::op_e		op,
	input	vu_pkg::data_t		a,				// First source operand
	input	vu_pkg::data_t		b,				// Second source operand
	input	vu_pkg::data_t		scalar,			// Scalar input for moves
	input	vu_pkg::tid_t		thread_id,
	output	vu_pkg::data_t		result
);

	import vu_pkg::*;

	data_t		lane_id_word;		// Global lane index of this thread
	logic [4:0]	shamt;

	assign shamt		= b[4:0];
	assign lane_id_word	= data_t'(thread_id) * data_t'(NUM_LANES) + data_t'(LANE_ID);

	always_comb begin
		case (op)
			OP_ADD:		result = a + b;
			OP_SUB:		result = a - b;
			OP_AND:		result = a & b;
			OP_OR:		result = a | b;
			OP_XOR:		result = a ^ b;
			OP_SLL:		result = a << shamt;
			OP_SRL:		result = a >> shamt;
			OP_MOVS:	result = scalar;
			OP_LANEID:	result = lane_id_word;
			default:	result = '0;			// Memory, rotate and readout ops
		endcase
	end

endmodule

/* vu_regfile.sv */
// Lane register file with two asynchronous read ports and one synchronous write port
module vu_regfile (
	input						clock,
	input						arst_n,
	input	vu_pkg::reg_idx_t	rd_addr1,		// First source index
	input	vu_pkg::reg_idx_t	rd_addr2,		// Second source index
	output	vu_pkg::data_t		rd_data1,
	output	vu_pkg::data_t		rd_data2,
	input						wr_en,			// Writeback strobe
	input	vu_pkg::reg_idx_t	wr_addr,
	input	vu_pkg::data_t		wr_data
);

	import vu_pkg::*;

	data_t	regs [NUM_REGS];	// Register storage

	assign rd_data1	= regs[rd_addr1];
	assign rd_data2	= regs[rd_addr2];

	// Registers start from zero so a fresh thread sees a clean state
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

endmodule

/* vu_pkg.sv */
// Vector unit package with lane sizing, data types and the command opcode set
package vu_pkg;

	////////////////////
	// Sizing
	////////////////////
	localparam int NUM_LANES	= 4;			// Default lane count
	localparam int DATA_W		= 32;			// Lane data width
	localparam int NUM_REGS		= 8;			// Registers per lane
	localparam int REG_W		= 3;			// Register index width
	localparam int ADDR_W		= 16;			// Memory word address width
	localparam int TID_W		= 8;			// Thread id width

	////////////////////
	// Types
	////////////////////
	typedef logic [DATA_W-1:0]	data_t;			// Data word
	typedef logic [REG_W-1:0]	reg_idx_t;		// Register index
	typedef logic [ADDR_W-1:0]	addr_t;			// Memory word address
	typedef logic [TID_W-1:0]	tid_t;			// SIMT thread id

	// Command opcodes, already decoded by the scalar side
	typedef enum logic [3:0] {
		OP_NOP		= 4'd0,			// No operation, lane stays idle
		OP_ADD		= 4'd1,
		OP_SUB		= 4'd2,
		OP_AND		= 4'd3,
		OP_OR		= 4'd4,
		OP_XOR		= 4'd5,
		OP_SLL		= 4'd6,			// Shift left by b[4:0]
		OP_SRL		= 4'd7,			// Logical shift right by b[4:0]
		OP_MOVS		= 4'd8,			// Move scalar input
		OP_LANEID	= 4'd9,			// thread_id * NUM_LANES + LANE_ID
		OP_ROTL		= 4'd10,		// Take upper neighbour's first source
		OP_LOAD		= 4'd11,		// rd <= mem[rs1]
		OP_STORE	= 4'd12,		// mem[rs1] <= rs2
		OP_RDS		= 4'd13			// Capture rs1 for scalar readout only
	} op_e;

endpackage
